//--- list.f
+incdir+include
hw/fams_pkg.sv
hw/bcd_arrange.sv
hw/gas_alarm.sv
hw/uart_tx.sv
hw/record_sender.sv
hw/fams_telemetry.sv
test/fams_asserts.sv
test/tb_fams.sv

//--- run.sh
#!/bin/sh
# build and run the telemetry testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f \
	--top-module tb_fams \
	-o sim_fams

status=0
./obj_dir/sim_fams +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -Fxq "** PASS **" sim.log && [ "$status" -eq 0 ]; then
	exit 0
fi
exit 1

//--- test/tb_fams.sv
`include "fams_consts.svh"

module tb_fams;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT = `FAMS_BIT_CYCLES;
	localparam int NBYTES = `FAMS_RECORD_BYTES;
	localparam int LIMIT = `FAMS_ALARM_LIMIT;

	logic			clk_50m;
	logic			rst_n;
	fams_pkg::sensor_bcd_t	readings;
	logic			txd_start;
	logic			bz;
	logic			hc06_rxd;

	int errors;
	int bytes_seen;		// frames seen on the serial line

	fams_telemetry i_dut (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.readings	(readings),
		.txd_start	(txd_start),
		.bz		(bz),
		.hc06_rxd	(hc06_rxd)
	);

	initial clk_50m = 1'b0;
	always #10 clk_50m = ~clk_50m;	// 50 MHz

	//------------------------------------------------------------------------
	// reading generation and expected record bytes
	//------------------------------------------------------------------------

	function automatic fams_pkg::bcd_pair_t to_pair(input int value);
		fams_pkg::bcd_pair_t p;
		p.tens = 4'(value / 10);
		p.ones = 4'(value % 10);
		return p;
	endfunction

	function automatic fams_pkg::bcd_pair_t random_pair();
		fams_pkg::bcd_pair_t p;
		p.tens = 4'($urandom % 10);
		p.ones = 4'($urandom % 10);
		return p;
	endfunction

	function automatic int pair_value(input fams_pkg::bcd_pair_t p);
		return int'(p.tens) * 10 + int'(p.ones);
	endfunction

	function automatic fams_pkg::sensor_bcd_t random_readings();
		fams_pkg::sensor_bcd_t r;
		r.body_temp_int = random_pair();
		r.body_temp_dec = random_pair();
		r.heart_rate_hun = 4'($urandom % 2);	// keeps heart rate in a byte
		r.heart_rate = random_pair();
		r.h2 = random_pair();
		r.liquefied = random_pair();
		r.natural = random_pair();
		r.harmful = random_pair();
		r.oxy = random_pair();
		r.temp = random_pair();
		r.hum = random_pair();
		return r;
	endfunction

	// gases at or just under the limit and oxygen at or over it
	function automatic fams_pkg::sensor_bcd_t safe_readings();
		fams_pkg::sensor_bcd_t r;
		r = random_readings();
		r.h2 = to_pair(LIMIT - int'($urandom % 3));
		r.liquefied = to_pair(LIMIT - int'($urandom % 3));
		r.natural = to_pair(LIMIT - int'($urandom % 3));
		r.harmful = to_pair(LIMIT - int'($urandom % 3));
		r.oxy = to_pair(LIMIT + int'($urandom % 10));
		return r;
	endfunction

	function automatic logic [7:0] expected_byte(input fams_pkg::sensor_bcd_t r, input int idx);
		int value;
		case (idx)
			9: value = pair_value(r.body_temp_int);
			8: value = pair_value(r.body_temp_dec);
			7: value = int'(r.heart_rate_hun) * 100 + pair_value(r.heart_rate);
			6: value = pair_value(r.h2);
			5: value = pair_value(r.liquefied);
			4: value = pair_value(r.natural);
			3: value = pair_value(r.harmful);
			2: value = pair_value(r.oxy);
			1: value = pair_value(r.temp);
			default: value = pair_value(r.hum);
		endcase
		return value[7:0];
	endfunction

	//------------------------------------------------------------------------
	// drivers and serial decoder
	//------------------------------------------------------------------------

	task automatic hold_readings(input fams_pkg::sensor_bcd_t r, input int cycles);
		@(posedge clk_50m);
		readings <= r;
		repeat (cycles) @(posedge clk_50m);
	endtask

	task automatic pulse_start();
		@(posedge clk_50m);
		txd_start <= 1'b1;
		@(posedge clk_50m);
		txd_start <= 1'b0;
	endtask

	task automatic wait_start_bit(input int limit, output bit found);
		found = 1'b0;
		for (int i = 0; i < limit && !found; i++) begin
			@(negedge clk_50m);
			if (!hc06_rxd) found = 1'b1;
		end
	endtask

	task automatic receive_byte(input int limit, output logic [7:0] data, output bit found);
		data = '0;
		wait_start_bit(limit, found);
		if (found) begin
			repeat (BIT / 2) @(negedge clk_50m);	// middle of start bit
			for (int b = 0; b < 8; b++) begin
				repeat (BIT) @(negedge clk_50m);
				data[b] = hc06_rxd;		// lsb first
			end
			repeat (BIT) @(negedge clk_50m);	// middle of stop bit
		end
	endtask

	task automatic check_record(input fams_pkg::sensor_bcd_t sent);
		logic [7:0] data;
		bit found;
		for (int idx = NBYTES - 1; idx >= 0; idx--) begin
			receive_byte((idx == NBYTES - 1) ? 8 : 2 * BIT, data, found);
			if (!found) begin
				$display("no start bit for record byte %0d by %0t", idx, $time);
				break;
			end
			bytes_seen++;
			if (data !== expected_byte(sent, idx)) begin
				$display("mismatch at %0t: hc06_rxd byte %0d got %02h expected %02h",
					$time, idx, data, expected_byte(sent, idx));
				errors++;
			end
		end
	endtask

	// the line has to stay idle once a record is done
	task automatic check_silence();
		bit found;
		wait_start_bit(3 * BIT, found);
		if (found) begin
			$display("unexpected start bit after the record at %0t", $time);
			bytes_seen++;
		end
	endtask

	//------------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------------

	initial begin
		fams_pkg::sensor_bcd_t r;
		fams_pkg::sensor_bcd_t sent;
		int assert_errors;
		void'($urandom(22189));
		errors = 0;
		bytes_seen = 0;
		rst_n = 1'b0;
		txd_start = 1'b0;
		readings = safe_readings();
		repeat (5) @(posedge clk_50m);
		rst_n <= 1'b1;

		r = safe_readings();	// every gas and oxygen exactly at the limit
		r.h2 = to_pair(LIMIT);
		r.liquefied = to_pair(LIMIT);
		r.natural = to_pair(LIMIT);
		r.harmful = to_pair(LIMIT);
		r.oxy = to_pair(LIMIT);
		hold_readings(r, 4);
		for (int g = 0; g < 5; g++) begin
			r = safe_readings();
			case (g)
				0: r.h2 = to_pair(LIMIT + 1);
				1: r.liquefied = to_pair(LIMIT + 1);
				2: r.natural = to_pair(LIMIT + 1);
				3: r.harmful = to_pair(LIMIT + 1);
				default: r.oxy = to_pair(LIMIT - 1);
			endcase
			hold_readings(r, 4);
			hold_readings(safe_readings(), 4);
		end
		repeat (40) hold_readings(random_readings(), 3);

		sent = random_readings();
		sent.heart_rate_hun = 4'd1;
		hold_readings(sent, 3);
		pulse_start();
		check_record(sent);
		check_silence();

		sent = random_readings();
		sent.heart_rate_hun = 4'd2;
		sent.heart_rate = to_pair(49);	// 249 bpm
		hold_readings(sent, 3);
		pulse_start();
		fork
			check_record(sent);
			begin
				repeat (2 * BIT) @(posedge clk_50m);
				pulse_start();		// ignored while the sender is busy
				hold_readings(random_readings(), BIT);
				hold_readings(random_readings(), BIT);
			end
		join
		check_silence();

		if (bytes_seen != 2 * NBYTES) begin
			$display("decoded %0d bytes in total, expected %0d", bytes_seen, 2 * NBYTES);
			errors++;
		end
		assert_errors = i_dut.u_fams_asserts.fail_count;
		$display("errors: decoder %0d, assertions %0d", errors, assert_errors);
		if (errors == 0 && assert_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- test/fams_asserts.sv
`include "fams_consts.svh"

module fams_asserts (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	fams_pkg::sensor_bcd_t	readings,
	input	logic			bz,
	input	logic			hc06_rxd
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT = `FAMS_BIT_CYCLES;
	localparam int FRAME = 10 * BIT;	// start, 8 data, stop
	localparam int LIMIT = `FAMS_ALARM_LIMIT;

	int fail_count = 0;	// failed assertions so far

	function automatic int pair_value(input fams_pkg::bcd_pair_t p);
		return int'(p.tens) * 10 + int'(p.ones);
	endfunction

	logic bz_rule;		// expected buzzer level for the current readings

	always_comb begin
		bz_rule = !((pair_value(readings.h2) > LIMIT)
			|| (pair_value(readings.liquefied) > LIMIT)
			|| (pair_value(readings.natural) > LIMIT)
			|| (pair_value(readings.harmful) > LIMIT)
			|| (pair_value(readings.oxy) < LIMIT));
	end

	//------------------------------------------------------------------------
	// frame position on the serial line
	//------------------------------------------------------------------------

	logic	line_q;
	logic	in_frame;
	int	frame_cnt;
	logic	start_seen;	// first low sample of a frame
	logic	framing;
	int	frame_pos;

	assign start_seen = !in_frame && line_q && !hc06_rxd;
	assign framing = start_seen || in_frame;
	assign frame_pos = start_seen ? 0 : frame_cnt;

	always_ff @(posedge clk_50m) begin
		if (!rst_n) begin
			line_q		<= 1'b1;
			in_frame	<= 1'b0;
			frame_cnt	<= 0;
		end else begin
			line_q <= hc06_rxd;
			if (start_seen) begin
				in_frame	<= 1'b1;
				frame_cnt	<= 1;
			end else if (in_frame) begin
				frame_cnt <= frame_cnt + 1;
				if (frame_cnt == FRAME - 1) in_frame <= 1'b0;
			end
		end
	end

	//------------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------------

	a_reset_idle: assert property (@(posedge clk_50m) !rst_n |=> (bz && hc06_rxd))
		else begin
			$error("bz or hc06_rxd not high after a reset cycle");
			fail_count++;
		end

	// two register stages from the readings to bz
	a_alarm_rule: assert property (@(posedge clk_50m) disable iff (!rst_n)
		($past(rst_n) && $past(rst_n, 2)) |-> (bz == $past(bz_rule, 2)))
		else begin
			$error("bz does not follow the alarm rule of two clocks earlier");
			fail_count++;
		end

	a_start_low: assert property (@(posedge clk_50m) disable iff (!rst_n)
		(framing && frame_pos < BIT) |-> !hc06_rxd)
		else begin
			$error("start bit not held low for a full bit period");
			fail_count++;
		end

	a_stop_high: assert property (@(posedge clk_50m) disable iff (!rst_n)
		(in_frame && frame_cnt >= 9 * BIT) |-> hc06_rxd)
		else begin
			$error("stop bit not held high for a full bit period");
			fail_count++;
		end

endmodule

bind fams_telemetry fams_asserts u_fams_asserts (
	.clk_50m	(clk_50m),
	.rst_n		(rst_n),
	.readings	(readings),
	.bz		(bz),
	.hc06_rxd	(hc06_rxd)
);

//--- hw/fams_telemetry.sv
module fams_telemetry (
	input	logic			clk_50m,	// 50MHz board clock
	input	logic			rst_n,
	input	fams_pkg::sensor_bcd_t	readings,	// bcd digits from the sensors
	input	logic			txd_start,	// send the record once
	output	logic			bz,		// active low buzzer
	output	logic			hc06_rxd	// bluetooth module serial input
);

	//------------------------------------------------------------------------
	// record and alarm
	//------------------------------------------------------------------------

	fams_pkg::record_t	record;

	bcd_arrange u_bcd_arrange (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.readings	(readings),
		.record		(record)
	);

	gas_alarm u_gas_alarm (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.record		(record),
		.bz		(bz)
	);

	//------------------------------------------------------------------------
	// bluetooth uart
	//------------------------------------------------------------------------

	logic		tx_load;
	logic [7:0]	tx_byte;
	logic		tx_busy;

	record_sender u_record_sender (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.txd_start	(txd_start),
		.record		(record),
		.tx_busy	(tx_busy),
		.tx_load	(tx_load),
		.tx_byte	(tx_byte),
		.busy		()
	);

	uart_tx u_uart_tx (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.tx_load	(tx_load),
		.tx_byte	(tx_byte),
		.tx_busy	(tx_busy),
		.txd		(hc06_rxd)
	);

endmodule

//--- hw/record_sender.sv
`include "fams_consts.svh"

module record_sender (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	logic			txd_start,	// one cycle pulse
	input	fams_pkg::record_t	record,		// live record
	input	logic			tx_busy,
	output	logic			tx_load,
	output	logic [7:0]		tx_byte,
	output	logic			busy		// latch to final stop bit
);

	localparam logic [3:0] FIRST_BYTE = 4'(`FAMS_RECORD_BYTES - 1);

	fams_pkg::record_t	snapshot;	// record held for the transfer
	logic [3:0]		byte_idx;
	logic			sent_all;	// final load issued

	//------------------------------------------------------------------------
	// byte sequencing
	//------------------------------------------------------------------------

	always_ff @(posedge clk_50m) begin
		if (!rst_n) begin
			busy		<= 1'b0;
			tx_load		<= 1'b0;
			byte_idx	<= '0;
			sent_all	<= 1'b0;
		end else if (!busy) begin
			if (txd_start) begin
				busy		<= 1'b1;
				byte_idx	<= FIRST_BYTE;
				sent_all	<= 1'b0;
			end
		end else if (tx_load) begin
			tx_load <= 1'b0;	// tx_busy rises on this edge
		end else if (!tx_busy) begin
			if (sent_all) begin
				busy <= 1'b0;
			end else begin
				tx_load <= 1'b1;
				if (byte_idx == 4'd0) begin
					sent_all <= 1'b1;
				end else begin
					byte_idx <= byte_idx - 4'd1;
				end
			end
		end
	end

	// payload path
	always_ff @(posedge clk_50m) begin
		if (!busy && txd_start) begin
			snapshot <= record;
		end
		if (busy && !tx_load && !tx_busy && !sent_all) begin
			tx_byte <= snapshot.bytes[byte_idx];	// byte 9 down to 0
		end
	end

endmodule

//--- hw/uart_tx.sv
`include "fams_consts.svh"

module uart_tx (
	input	logic		clk_50m,
	input	logic		rst_n,
	input	logic		tx_load,	// one cycle, only while idle
	input	logic [7:0]	tx_byte,
	output	logic		tx_busy,	// high through the stop bit
	output	logic		txd		// serial line, idles high
);

	localparam int CNT_W = $clog2(`FAMS_BIT_CYCLES);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`FAMS_BIT_CYCLES - 1);

	logic [CNT_W-1:0]	bit_cnt;	// clocks within the current bit
	logic [3:0]		bit_idx;	// 0 start, 1..8 data, 9 stop
	logic [8:0]		shifter;	// data lsb first, then stop bit

	//------------------------------------------------------------------------
	// 8n1 frame
	//------------------------------------------------------------------------

	always_ff @(posedge clk_50m) begin
		if (!rst_n) begin
			tx_busy	<= 1'b0;
			txd	<= 1'b1;
			bit_cnt	<= '0;
			bit_idx	<= '0;
			shifter	<= '1;
		end else if (!tx_busy) begin
			if (tx_load) begin
				tx_busy	<= 1'b1;
				txd	<= 1'b0;		// start bit
				bit_cnt	<= '0;
				bit_idx	<= '0;
				shifter	<= {1'b1, tx_byte};
			end
		end else if (bit_cnt == BIT_LAST) begin
			bit_cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;	// stop bit done, line stays high
			end else begin
				bit_idx	<= bit_idx + 4'd1;
				txd	<= shifter[0];
				shifter	<= {1'b1, shifter[8:1]};
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

endmodule

//--- hw/gas_alarm.sv
`include "fams_consts.svh"

module gas_alarm (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	fams_pkg::record_t	record,
	output	logic			bz		// low sounds the buzzer
);

	localparam logic [7:0] LIMIT = 8'(`FAMS_ALARM_LIMIT);

	logic gas_high;
	logic oxy_low;

	// any of the four gases strictly over the limit
	assign gas_high = (record.fields.h2 > LIMIT)
			| (record.fields.liquefied > LIMIT)
			| (record.fields.natural > LIMIT)
			| (record.fields.harmful > LIMIT);

	assign oxy_low = (record.fields.oxy < LIMIT);	// exactly 20 is safe

	always_ff @(posedge clk_50m) begin
		if (!rst_n) begin
			bz <= 1'b1;			// silent
		end else begin
			bz <= ~(gas_high | oxy_low);
		end
	end

endmodule

//--- hw/bcd_arrange.sv
module bcd_arrange (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	fams_pkg::sensor_bcd_t	readings,	// digits held as levels
	output	fams_pkg::record_t	record		// binary record, one clock later
);

	//------------------------------------------------------------------------
	// digit weighting
	//------------------------------------------------------------------------

	// tens * 10 + ones, always fits in a byte
	function automatic logic [7:0] pair_to_bin(input fams_pkg::bcd_pair_t p);
		logic [7:0] tens_w;
		logic [7:0] ones_w;
		tens_w = {4'd0, p.tens};
		ones_w = {4'd0, p.ones};
		return (tens_w * 8'd10) + ones_w;
	endfunction

	fams_pkg::record_t	record_d;
	logic [9:0]		heart_sum;	// up to 999 before truncation

	always_comb begin
		heart_sum = ({6'd0, readings.heart_rate_hun} * 10'd100)
			  + {2'd0, pair_to_bin(readings.heart_rate)};

		record_d.fields.body_temp_int	= pair_to_bin(readings.body_temp_int);
		record_d.fields.body_temp_dec	= pair_to_bin(readings.body_temp_dec);
		record_d.fields.heart_rate	= heart_sum[7:0];	// byte wide field
		record_d.fields.h2		= pair_to_bin(readings.h2);
		record_d.fields.liquefied	= pair_to_bin(readings.liquefied);
		record_d.fields.natural		= pair_to_bin(readings.natural);
		record_d.fields.harmful		= pair_to_bin(readings.harmful);
		record_d.fields.oxy		= pair_to_bin(readings.oxy);
		record_d.fields.temp		= pair_to_bin(readings.temp);
		record_d.fields.hum		= pair_to_bin(readings.hum);
	end

	//------------------------------------------------------------------------
	// record register
	//------------------------------------------------------------------------

	always_ff @(posedge clk_50m) begin
		if (!rst_n) begin
			record <= '0;
		end else begin
			record <= record_d;	// all ten bytes in one step
		end
	end

endmodule

//--- hw/fams_pkg.sv
`include "fams_consts.svh"

package fams_pkg;

	//------------------------------------------------------------------------
	// bcd readings from the sensor side
	//------------------------------------------------------------------------

	typedef struct packed {
		logic [`FAMS_DIGIT_W-1:0]	tens;		// upper digit
		logic [`FAMS_DIGIT_W-1:0]	ones;		// lower digit
	} bcd_pair_t;

	typedef struct packed {
		bcd_pair_t			body_temp_int;	// degrees
		bcd_pair_t			body_temp_dec;	// hundredths
		logic [`FAMS_DIGIT_W-1:0]	heart_rate_hun;	// third digit of heart rate
		bcd_pair_t			heart_rate;
		bcd_pair_t			h2;
		bcd_pair_t			liquefied;
		bcd_pair_t			natural;
		bcd_pair_t			harmful;
		bcd_pair_t			oxy;
		bcd_pair_t			temp;		// ambient temperature
		bcd_pair_t			hum;		// relative humidity
	} sensor_bcd_t;

	//------------------------------------------------------------------------
	// binary record, sent byte 9 first
	//------------------------------------------------------------------------

	typedef struct packed {
		logic [7:0]	body_temp_int;	// byte 9
		logic [7:0]	body_temp_dec;
		logic [7:0]	heart_rate;
		logic [7:0]	h2;
		logic [7:0]	liquefied;
		logic [7:0]	natural;
		logic [7:0]	harmful;
		logic [7:0]	oxy;
		logic [7:0]	temp;
		logic [7:0]	hum;		// byte 0
	} record_fields_t;

	// alarm reads by name, sender by byte index
	typedef union packed {
		record_fields_t					fields;
		logic [`FAMS_RECORD_BYTES-1:0][7:0]	bytes;
	} record_t;

endpackage

//--- include/fams_consts.svh
`ifndef FAMS_CONSTS_SVH
`define FAMS_CONSTS_SVH

//----------------------------------------------------------------------------
// alarm and serial link constants
//----------------------------------------------------------------------------

// gas readings above this and oxygen below it sound the buzzer
`define FAMS_ALARM_LIMIT	20

// clocks per uart bit, 50 MHz / 115200 baud
`define FAMS_BIT_CYCLES		434

//----------------------------------------------------------------------------
// record format
//----------------------------------------------------------------------------

`define FAMS_RECORD_BYTES	10	// bytes per telemetry record
`define FAMS_DIGIT_W		4	// one bcd digit

`endif
